/* rtl/tri_asm_settings.svh */
`ifndef TRI_ASM_SETTINGS_SVH
`define TRI_ASM_SETTINGS_SVH

// word and fixed-point format
`define TA_WORD_W          32
`define TA_FRAC_BITS       16

// vertex record layout, in words
`define TA_VERTEX_STRIDE   12
`define TA_COLOUR_OFFSET   8   // position sits at word 0, words 4..7 unused

`define TA_BYTES_PER_WORD  4

`endif

/* rtl/tri_asm_pkg.sv */
`default_nettype none

`include "tri_asm_settings.svh"

package tri_asm_pkg;

    // signed 16.16
    typedef logic signed [`TA_WORD_W-1:0] fixed_t;

    // x in the top word
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
        fixed_t w;
    } vec4_t;

    // element r*4+c is row r, column c
    typedef fixed_t [15:0] mat44_t;

endpackage

`default_nettype wire

/* rtl/vertex_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tri_asm_settings.svh"

module vertex_fetch (
    input  wire logic                      i_clk,
    input  wire logic                      i_reset_n,
    input  wire logic                      i_start,
    input  wire logic [`TA_WORD_W-1:0]     i_address_index_buffer,
    input  wire logic [`TA_WORD_W-1:0]     i_address_vertex_buffer,
    input  wire logic [`TA_WORD_W-1:0]     i_num_triangles,
    input  wire logic [`TA_WORD_W-1:0]     i_memory_data,
    input  wire logic                      i_next_free,
    input  wire logic                      i_done,
    output logic                           o_ready,
    output logic                           o_memory_read,
    output logic [`TA_WORD_W-1:0]          o_memory_address,
    output logic                           o_valid,
    output logic                           o_last,
    output tri_asm_pkg::vec4_t             o_v1, o_v2, o_v3,
    output tri_asm_pkg::vec4_t             o_c1, o_c2, o_c3
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_HAND, S_DRAIN} state_t;

    state_t                   r_state;
    logic [4:0]               r_read;         // read on the bus, 0..26
    logic [`TA_WORD_W-1:0]    r_tri;          // triangle being fetched
    logic [`TA_WORD_W-1:0]    r_index_ptr;    // next index word address
    logic [`TA_WORD_W-1:0]    r_num;
    logic [`TA_WORD_W-1:0]    r_vertex_base;
    logic [`TA_WORD_W-1:0]    r_index [0:2];
    tri_asm_pkg::fixed_t      r_word [0:23];  // positions then colours

    logic                     w_accept;
    logic [4:0]               w_slot;
    logic [2:0]               w_group;
    logic                     w_colour;
    logic [1:0]               w_sel;
    logic [`TA_WORD_W-1:0]    w_field;
    logic [`TA_WORD_W-1:0]    w_vertex_addr;

    assign w_accept = (r_state == S_IDLE) && i_start && o_ready;

    //////////////////////////////////////////////////////////////////////
    // address of the next vertex read
    //////////////////////////////////////////////////////////////////////

    assign w_slot   = r_read - 5'd2;                  // word slot of read r_read+1
    assign w_group  = w_slot[4:2];                    // 0..2 positions, 3..5 colours
    assign w_colour = (w_group >= 3'd3);
    assign w_sel    = w_colour ? 2'(w_group - 3'd3) : w_group[1:0];
    assign w_field  = (w_colour ? `TA_COLOUR_OFFSET : 0) + {{(`TA_WORD_W-2){1'b0}}, w_slot[1:0]};

    assign w_vertex_addr = r_vertex_base
                         + (r_index[w_sel] * `TA_VERTEX_STRIDE + w_field) * `TA_BYTES_PER_WORD;

    //////////////////////////////////////////////////////////////////////
    // request and read sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_state          <= S_IDLE;
            r_read           <= '0;
            r_tri            <= '0;
            r_index_ptr      <= '0;
            o_ready          <= 1'b1;
            o_memory_read    <= 1'b0;
            o_memory_address <= '0;
        end else begin
            case (r_state)
                S_IDLE: begin
                    o_ready <= 1'b1;
                    if (w_accept) begin
                        o_ready     <= 1'b0;
                        r_tri       <= '0;
                        r_index_ptr <= i_address_index_buffer + `TA_BYTES_PER_WORD;
                        if (i_num_triangles != '0) begin   // empty request stays idle
                            r_state          <= S_READ;
                            r_read           <= '0;
                            o_memory_read    <= 1'b1;
                            o_memory_address <= i_address_index_buffer;
                        end
                    end
                end
                S_READ: begin
                    r_read <= r_read + 5'd1;
                    if (r_read < 5'd2) begin
                        o_memory_address <= r_index_ptr;
                        r_index_ptr      <= r_index_ptr + `TA_BYTES_PER_WORD;
                    end else if (r_read < 5'd26) begin
                        o_memory_address <= w_vertex_addr;
                    end else begin
                        o_memory_read <= 1'b0;        // last colour word on the bus
                        r_state       <= S_HAND;
                    end
                end
                S_HAND: begin
                    if (i_next_free) begin
                        r_tri <= r_tri + 1'b1;
                        if (o_last) begin
                            r_state <= S_DRAIN;
                        end else begin
                            r_state          <= S_READ;
                            r_read           <= '0;
                            o_memory_read    <= 1'b1;
                            o_memory_address <= r_index_ptr;
                            r_index_ptr      <= r_index_ptr + `TA_BYTES_PER_WORD;
                        end
                    end
                end
                default: begin                        // S_DRAIN
                    if (i_done) begin
                        o_ready <= 1'b1;
                        r_state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // request values and fetched words
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_num         <= i_num_triangles;
            r_vertex_base <= i_address_vertex_buffer;
        end
        if (r_state == S_READ) begin
            if (r_read < 5'd3) r_index[r_read[1:0]] <= i_memory_data;
            else               r_word[r_read - 5'd3] <= i_memory_data;
        end
    end

    assign o_valid = (r_state == S_HAND) && i_next_free;
    assign o_last  = (r_tri + 1'b1 == r_num);

    assign o_v1 = {r_word[0],  r_word[1],  r_word[2],  r_word[3]};
    assign o_v2 = {r_word[4],  r_word[5],  r_word[6],  r_word[7]};
    assign o_v3 = {r_word[8],  r_word[9],  r_word[10], r_word[11]};
    assign o_c1 = {r_word[12], r_word[13], r_word[14], r_word[15]};
    assign o_c2 = {r_word[16], r_word[17], r_word[18], r_word[19]};
    assign o_c3 = {r_word[20], r_word[21], r_word[22], r_word[23]};

endmodule

`default_nettype wire

/* rtl/world_transform.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tri_asm_settings.svh"

module world_transform (
    input  wire logic                  i_clk,
    input  wire logic                  i_reset_n,
    input  wire logic                  i_start,
    input  wire tri_asm_pkg::mat44_t   i_world,
    input  wire logic                  i_valid,
    input  wire logic                  i_last,
    input  wire tri_asm_pkg::vec4_t    i_v1, i_v2, i_v3,
    input  wire tri_asm_pkg::vec4_t    i_c1, i_c2, i_c3,
    input  wire logic                  i_next_free,
    output logic                       o_free,
    output logic                       o_valid,
    output logic                       o_last,
    output tri_asm_pkg::vec4_t         o_v1, o_v2, o_v3,
    output tri_asm_pkg::vec4_t         o_c1, o_c2, o_c3
);

    typedef enum logic [1:0] {S_EMPTY, S_CALC, S_HOLD} state_t;

    state_t                  r_state;
    tri_asm_pkg::mat44_t     r_world;
    tri_asm_pkg::vec4_t      r_v1, r_v2, r_v3;   // input positions, then results
    tri_asm_pkg::vec4_t      r_c1, r_c2, r_c3;
    logic                    r_last;

    // 16.16 product, full width then shifted and truncated
    function automatic tri_asm_pkg::fixed_t fx_mul(input tri_asm_pkg::fixed_t a,
                                                   input tri_asm_pkg::fixed_t b);
        logic signed [2*`TA_WORD_W-1:0] prod;
        prod   = a * b;
        fx_mul = prod[`TA_FRAC_BITS +: `TA_WORD_W];
    endfunction

    function automatic tri_asm_pkg::vec4_t mat_vec(input tri_asm_pkg::mat44_t m,
                                                   input tri_asm_pkg::vec4_t v);
        tri_asm_pkg::fixed_t in_c [4];
        tri_asm_pkg::fixed_t out_c [4];
        in_c = '{v.x, v.y, v.z, v.w};
        for (int r = 0; r < 4; r++) begin
            out_c[r] = '0;
            for (int c = 0; c < 4; c++) begin
                out_c[r] = out_c[r] + fx_mul(m[r*4 + c], in_c[c]);   // wraps mod 2^32
            end
        end
        mat_vec = {out_c[0], out_c[1], out_c[2], out_c[3]};
    endfunction

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_state <= S_EMPTY;
        end else begin
            case (r_state)
                S_EMPTY: if (i_valid) r_state <= S_CALC;
                S_CALC:  r_state <= S_HOLD;
                default: if (i_next_free) r_state <= S_EMPTY;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) r_world <= i_world;
        if (i_valid && o_free) begin
            {r_v1, r_v2, r_v3} <= {i_v1, i_v2, i_v3};
            {r_c1, r_c2, r_c3} <= {i_c1, i_c2, i_c3};
            r_last             <= i_last;
        end else if (r_state == S_CALC) begin
            r_v1 <= mat_vec(r_world, r_v1);     // transform in place
            r_v2 <= mat_vec(r_world, r_v2);
            r_v3 <= mat_vec(r_world, r_v3);
        end
    end

    assign o_free  = (r_state == S_EMPTY);
    assign o_valid = (r_state == S_HOLD) && i_next_free;
    assign o_last  = r_last;
    assign {o_v1, o_v2, o_v3} = {r_v1, r_v2, r_v3};
    assign {o_c1, o_c2, o_c3} = {r_c1, r_c2, r_c3};   // colours pass through

endmodule

`default_nettype wire

/* rtl/backface_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module backface_issue (
    input  wire logic                  i_clk,
    input  wire logic                  i_reset_n,
    input  wire logic                  i_valid,
    input  wire logic                  i_last,
    input  wire tri_asm_pkg::vec4_t    i_v1, i_v2, i_v3,
    input  wire tri_asm_pkg::vec4_t    i_c1, i_c2, i_c3,
    input  wire logic                  i_rasterizer_ready,
    output logic                       o_free,
    output logic                       o_done,
    output logic                       o_valid,
    output tri_asm_pkg::vec4_t         o_v1, o_v2, o_v3,
    output tri_asm_pkg::vec4_t         o_c1, o_c2, o_c3
);

    typedef enum logic [1:0] {S_EMPTY, S_DECIDE, S_WAIT, S_ISSUE} state_t;

    state_t                  r_state;
    tri_asm_pkg::vec4_t      r_v1, r_v2, r_v3;
    tri_asm_pkg::vec4_t      r_c1, r_c2, r_c3;
    logic                    r_last;

    tri_asm_pkg::fixed_t     w_dx2, w_dy2, w_dx3, w_dy3;
    logic signed [63:0]      w_cross;
    logic                    w_cull;

    //////////////////////////////////////////////////////////////////////
    // winding test in screen x/y
    //////////////////////////////////////////////////////////////////////

    assign w_dx2 = r_v2.x - r_v1.x;               // 32-bit wrapped differences
    assign w_dy2 = r_v2.y - r_v1.y;
    assign w_dx3 = r_v3.x - r_v1.x;
    assign w_dy3 = r_v3.y - r_v1.y;

    assign w_cross = w_dx2 * w_dy3 - w_dx3 * w_dy2;
    assign w_cull  = (w_cross <= 64'sd0);         // back facing or degenerate

    //////////////////////////////////////////////////////////////////////
    // hold and issue
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_state <= S_EMPTY;
        end else begin
            case (r_state)
                S_EMPTY: begin
                    if (i_valid) r_state <= S_DECIDE;
                end
                S_DECIDE: begin
                    if (w_cull)                  r_state <= S_EMPTY;    // dropped here
                    else if (i_rasterizer_ready) r_state <= S_ISSUE;
                    else                         r_state <= S_WAIT;
                end
                S_WAIT: begin
                    if (i_rasterizer_ready) r_state <= S_ISSUE;
                end
                default: r_state <= S_EMPTY;      // one cycle of o_valid
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_free) begin
            {r_v1, r_v2, r_v3} <= {i_v1, i_v2, i_v3};
            {r_c1, r_c2, r_c3} <= {i_c1, i_c2, i_c3};
            r_last             <= i_last;
        end
    end

    assign o_free  = (r_state == S_EMPTY);
    assign o_valid = (r_state == S_ISSUE);
    // the request is finished once its last triangle leaves either way
    assign o_done  = r_last && (o_valid || ((r_state == S_DECIDE) && w_cull));

    assign {o_v1, o_v2, o_v3} = {r_v1, r_v2, r_v3};
    assign {o_c1, o_c2, o_c3} = {r_c1, r_c2, r_c3};

endmodule

`default_nettype wire

/* rtl/triangle_assembly.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tri_asm_settings.svh"

module triangle_assembly (
    input  wire logic                      i_clk,
    input  wire logic                      i_reset_n,
    input  wire logic                      i_start,
    input  wire logic [`TA_WORD_W-1:0]     i_address_index_buffer,
    input  wire logic [`TA_WORD_W-1:0]     i_address_vertex_buffer,
    input  wire logic [`TA_WORD_W-1:0]     i_num_triangles,
    input  wire tri_asm_pkg::mat44_t       i_world,
    output logic                           o_memory_read,
    output logic [`TA_WORD_W-1:0]          o_memory_address,
    input  wire logic [`TA_WORD_W-1:0]     i_memory_data,
    input  wire logic                      i_rasterizer_ready,
    output logic                           o_valid,
    output tri_asm_pkg::vec4_t             o_v1, o_v2, o_v3,
    output tri_asm_pkg::vec4_t             o_c1, o_c2, o_c3,
    output logic                           o_ready
);

    // fetch -> transform
    logic                  w_fetch_valid, w_fetch_last, w_xf_free;
    tri_asm_pkg::vec4_t    w_fetch_v1, w_fetch_v2, w_fetch_v3;
    tri_asm_pkg::vec4_t    w_fetch_c1, w_fetch_c2, w_fetch_c3;

    // transform -> issue
    logic                  w_xf_valid, w_xf_last, w_issue_free, w_done;
    tri_asm_pkg::vec4_t    w_xf_v1, w_xf_v2, w_xf_v3;
    tri_asm_pkg::vec4_t    w_xf_c1, w_xf_c2, w_xf_c3;

    vertex_fetch i_vertex_fetch (
        .i_clk, .i_reset_n, .i_start,
        .i_address_index_buffer, .i_address_vertex_buffer, .i_num_triangles,
        .i_memory_data,
        .i_next_free      (w_xf_free),
        .i_done           (w_done),
        .o_ready, .o_memory_read, .o_memory_address,
        .o_valid          (w_fetch_valid),
        .o_last           (w_fetch_last),
        .o_v1 (w_fetch_v1), .o_v2 (w_fetch_v2), .o_v3 (w_fetch_v3),
        .o_c1 (w_fetch_c1), .o_c2 (w_fetch_c2), .o_c3 (w_fetch_c3)
    );

    world_transform i_world_transform (
        .i_clk, .i_reset_n,
        .i_start          (i_start && o_ready),   // accepted requests only
        .i_world,
        .i_valid          (w_fetch_valid),
        .i_last           (w_fetch_last),
        .i_v1 (w_fetch_v1), .i_v2 (w_fetch_v2), .i_v3 (w_fetch_v3),
        .i_c1 (w_fetch_c1), .i_c2 (w_fetch_c2), .i_c3 (w_fetch_c3),
        .i_next_free      (w_issue_free),
        .o_free           (w_xf_free),
        .o_valid          (w_xf_valid),
        .o_last           (w_xf_last),
        .o_v1 (w_xf_v1), .o_v2 (w_xf_v2), .o_v3 (w_xf_v3),
        .o_c1 (w_xf_c1), .o_c2 (w_xf_c2), .o_c3 (w_xf_c3)
    );

    backface_issue i_backface_issue (
        .i_clk, .i_reset_n,
        .i_valid          (w_xf_valid),
        .i_last           (w_xf_last),
        .i_v1 (w_xf_v1), .i_v2 (w_xf_v2), .i_v3 (w_xf_v3),
        .i_c1 (w_xf_c1), .i_c2 (w_xf_c2), .i_c3 (w_xf_c3),
        .i_rasterizer_ready,
        .o_free           (w_issue_free),
        .o_done           (w_done),
        .o_valid,
        .o_v1, .o_v2, .o_v3, .o_c1, .o_c2, .o_c3
    );

endmodule

`default_nettype wire

/* verification/triangle_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tri_asm_settings.svh"

module triangle_checker (
    input  wire logic                      i_clk,
    input  wire logic                      i_reset_n,
    input  wire logic                      i_start,
    input  wire logic [`TA_WORD_W-1:0]     i_index_base,
    input  wire logic [`TA_WORD_W-1:0]     i_vertex_base,
    input  wire logic [`TA_WORD_W-1:0]     i_num_triangles,
    input  wire tri_asm_pkg::mat44_t       i_world,
    input  wire logic                      i_memory_read,
    input  wire logic [`TA_WORD_W-1:0]     i_memory_address,
    input  wire logic [`TA_WORD_W-1:0]     i_memory_data,
    input  wire logic                      i_rasterizer_ready,
    input  wire logic                      i_valid,
    input  wire tri_asm_pkg::vec4_t        i_v1, i_v2, i_v3,
    input  wire tri_asm_pkg::vec4_t        i_c1, i_c2, i_c3,
    input  wire logic                      i_ready,
    output int                             o_errors,
    output int                             o_tests
);

    int                       errors, tests, rd, exp_issue, got_issue, culled, test_errs;
    logic                     busy, fall_due, zero_due, prev_ready, prev_rr;
    logic [`TA_WORD_W-1:0]    ib, vb, num, tri_n, exp_addr;
    logic [`TA_WORD_W-1:0]    idx [3];
    logic [`TA_WORD_W-1:0]    word [24];                // positions then colours
    tri_asm_pkg::mat44_t      world;
    logic [767:0]             exp_q [$];                // {v1, v2, v3, c1, c2, c3}
    logic [767:0]             head;

    assign o_errors = errors;
    assign o_tests  = tests;

    function automatic tri_asm_pkg::vec4_t apply_world(input tri_asm_pkg::mat44_t m,
                                                       input logic [127:0] v);
        logic [31:0] in_c [4];
        logic [31:0] res [4];
        logic [31:0] acc;
        longint      prod;
        in_c[0] = v[127:96];
        in_c[1] = v[95:64];
        in_c[2] = v[63:32];
        in_c[3] = v[31:0];
        for (int r = 0; r < 4; r++) begin
            acc = '0;
            for (int c = 0; c < 4; c++) begin
                prod = longint'($signed(m[r*4 + c])) * longint'($signed(in_c[c]));
                acc  = acc + 32'(prod >>> `TA_FRAC_BITS);
            end
            res[r] = acc;
        end
        return {res[0], res[1], res[2], res[3]};
    endfunction

    function automatic logic front_facing(input tri_asm_pkg::vec4_t a, b, c);
        logic signed [31:0] dx2, dy2, dx3, dy3;
        longint             cr;
        dx2 = b.x - a.x;
        dy2 = b.y - a.y;
        dx3 = c.x - a.x;
        dy3 = c.y - a.y;
        cr  = longint'(dx2) * longint'(dy3) - longint'(dx3) * longint'(dy2);
        return cr > 0;
    endfunction

    task automatic report(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic check_vec(input string name, input logic [127:0] exp, got);
        if (exp !== got) begin
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // models one fetched triangle once its last colour word is read
    task automatic finish_triangle();
        tri_asm_pkg::vec4_t t1, t2, t3;
        t1 = apply_world(world, {word[0], word[1], word[2], word[3]});
        t2 = apply_world(world, {word[4], word[5], word[6], word[7]});
        t3 = apply_world(world, {word[8], word[9], word[10], word[11]});
        if (front_facing(t1, t2, t3)) begin
            exp_q.push_back({t1, t2, t3,
                             word[12], word[13], word[14], word[15],
                             word[16], word[17], word[18], word[19],
                             word[20], word[21], word[22], word[23]});
            exp_issue++;
        end else begin
            culled++;
        end
        tri_n++;
        rd = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // watch each cycle on values from before this edge's register updates
    //////////////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy       = 1'b0;
            fall_due   = 1'b0;
            zero_due   = 1'b0;
            prev_ready = 1'b1;
            prev_rr    = 1'b0;
            rd         = 0;
        end else begin
            if (zero_due) begin
                zero_due = 1'b0;
                if (i_ready !== 1'b1) report("zero-triangle request did not end after one cycle");
            end
            if (fall_due) begin
                fall_due = 1'b0;
                if (i_ready !== 1'b0) report("o_ready did not fall after an accepted start");
                zero_due = (num == 0);
            end

            // end of a request
            if (!prev_ready && i_ready && busy) begin
                if (tri_n != num)     report("request ended before all triangles were fetched");
                if (exp_q.size() != 0) report("request ended with triangles still pending");
                if (got_issue != exp_issue) begin
                    $display("Mismatch at %0t ns: issue count expected %0d got %0d",
                             $time, exp_issue, got_issue);
                    errors++;
                end
                $display("test %0d: %0d triangles, %0d issued, %0d culled, %s", tests, num,
                         got_issue, culled, (errors == test_errs) ? "ok" : "FAILED");
                tests++;
                busy = 1'b0;
            end

            if (i_start && i_ready) begin
                ib        = i_index_base;
                vb        = i_vertex_base;
                num       = i_num_triangles;
                world     = i_world;
                busy      = 1'b1;
                fall_due  = 1'b1;
                tri_n     = '0;
                rd        = 0;
                exp_issue = 0;
                got_issue = 0;
                culled    = 0;
                test_errs = errors;
            end

            if (i_memory_read) begin
                if (!busy || tri_n >= num) begin
                    report("memory read outside a request");
                end else begin
                    if (rd < 3)
                        exp_addr = ib + (3*tri_n + rd) * `TA_BYTES_PER_WORD;
                    else if (rd < 15)
                        exp_addr = vb + (`TA_VERTEX_STRIDE*idx[(rd-3)/4] + (rd-3)%4)
                                 * `TA_BYTES_PER_WORD;
                    else
                        exp_addr = vb + (`TA_VERTEX_STRIDE*idx[(rd-15)/4] + `TA_COLOUR_OFFSET
                                 + (rd-15)%4) * `TA_BYTES_PER_WORD;
                    if (i_memory_address !== exp_addr) begin
                        $display("Mismatch at %0t ns: o_memory_address expected %h got %h",
                                 $time, exp_addr, i_memory_address);
                        errors++;
                    end
                    if (rd < 3) idx[rd] = i_memory_data;
                    else        word[rd-3] = i_memory_data;
                    rd++;
                    if (rd == 27) finish_triangle();
                end
            end else if (rd != 0) begin
                report("memory read sequence broke off inside a triangle");
                rd = 0;
            end

            if (i_valid) begin
                if (!prev_rr) report("o_valid without rasterizer ready in the cycle before");
                if (exp_q.size() == 0) begin
                    report("o_valid with no front-facing triangle pending");
                end else begin
                    head = exp_q.pop_front();
                    check_vec("o_v1", head[767:640], i_v1);
                    check_vec("o_v2", head[639:512], i_v2);
                    check_vec("o_v3", head[511:384], i_v3);
                    check_vec("o_c1", head[383:256], i_c1);
                    check_vec("o_c2", head[255:128], i_c2);
                    check_vec("o_c3", head[127:0],   i_c3);
                end
                got_issue++;
            end

            prev_ready = i_ready;
            prev_rr    = i_rasterizer_ready;
        end
    end

    initial begin
        errors = 0;
        tests  = 0;
    end

endmodule

`default_nettype wire

/* verification/tb_triangle_assembly.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tri_asm_settings.svh"

module tb_triangle_assembly;

    localparam int NUM_REQ     = 5;
    localparam int TOTAL_TRI   = 5 + 0 + 8 + 6 + 7;
    localparam int CYCLE_LIMIT = TOTAL_TRI * (27 + 64) + NUM_REQ * 40 + 20;

    logic                    clk = 1'b0;
    logic                    reset_n = 1'b0;
    logic                    start = 1'b0;
    logic [`TA_WORD_W-1:0]   index_base = '0;
    logic [`TA_WORD_W-1:0]   vertex_base = '0;
    logic [`TA_WORD_W-1:0]   num_triangles = '0;
    tri_asm_pkg::mat44_t     world = '0;
    logic                    rasterizer_ready = 1'b0;
    logic                    stall_mode = 1'b0;      // long stretches of ready low
    logic                    memory_read, valid, ready;
    logic [`TA_WORD_W-1:0]   memory_address, memory_data;
    tri_asm_pkg::vec4_t      v1, v2, v3, c1, c2, c3;
    int                      errors, tests, cycles;
    logic [31:0]             stim_seed = 32'd3;
    logic [31:0]             ready_seed = 32'd3;
    logic [31:0]             mem [0:4095];

    int   req_count [NUM_REQ] = '{5, 0, 8, 6, 7};
    logic req_stall [NUM_REQ] = '{0, 0, 0, 0, 1};

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function logic [31:0] rand_stim();
        stim_seed = lcg_next(stim_seed);
        return {8'h00, stim_seed[31:8]};
    endfunction

    // signed value with the given number of low bits, sign extended
    function logic [31:0] small_fixed(input int bits);
        logic [31:0] r;
        r = rand_stim();
        return 32'($signed(r << (32 - bits)) >>> (32 - bits));
    endfunction

    assign memory_data = mem[memory_address[13:2]];   // same-cycle read

    triangle_assembly i_triangle_assembly (
        .i_clk(clk), .i_reset_n(reset_n), .i_start(start),
        .i_address_index_buffer(index_base), .i_address_vertex_buffer(vertex_base),
        .i_num_triangles(num_triangles), .i_world(world),
        .o_memory_read(memory_read), .o_memory_address(memory_address),
        .i_memory_data(memory_data), .i_rasterizer_ready(rasterizer_ready),
        .o_valid(valid), .o_v1(v1), .o_v2(v2), .o_v3(v3),
        .o_c1(c1), .o_c2(c2), .o_c3(c3), .o_ready(ready)
    );

    triangle_checker i_triangle_checker (
        .i_clk(clk), .i_reset_n(reset_n), .i_start(start),
        .i_index_base(index_base), .i_vertex_base(vertex_base),
        .i_num_triangles(num_triangles), .i_world(world),
        .i_memory_read(memory_read), .i_memory_address(memory_address),
        .i_memory_data(memory_data), .i_rasterizer_ready(rasterizer_ready),
        .i_valid(valid), .i_v1(v1), .i_v2(v2), .i_v3(v3),
        .i_c1(c1), .i_c2(c2), .i_c3(c3), .i_ready(ready),
        .o_errors(errors), .o_tests(tests)
    );

    // rasterizer ready toggles from its own stream
    always @(posedge clk) begin
        ready_seed = lcg_next(ready_seed);
        if (stall_mode) rasterizer_ready <= (ready_seed[27:24] == 4'd0);
        else            rasterizer_ready <= (ready_seed[25:24] != 2'd0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // one request, with a stray start while it is busy
    //////////////////////////////////////////////////////////////////////

    task automatic run_request(input int slot);
        tri_asm_pkg::mat44_t m;
        for (int e = 0; e < 16; e++) m[e] = small_fixed(18);   // about +-2.0
        @(posedge clk);
        stall_mode    <= req_stall[slot];
        start         <= 1'b1;
        index_base    <= (1024 + slot*64) * `TA_BYTES_PER_WORD;
        vertex_base   <= (slot[0] ? 2240 : 2048) * `TA_BYTES_PER_WORD;
        num_triangles <= req_count[slot];
        world         <= m;
        @(posedge clk);
        start <= 1'b0;
        if (req_count[slot] != 0) begin
            repeat (3 + rand_stim() % 20) @(posedge clk);
            start         <= 1'b1;                 // must be ignored
            num_triangles <= 32'd3;
            index_base    <= 32'h0000_0100;
            world         <= '1;
            @(posedge clk);
            start <= 1'b0;
        end
        @(posedge clk);
        while (!ready) @(posedge clk);
    endtask

    initial begin
        cycles = 0;
        for (int a = 0; a < 4096; a++) mem[a] = (a * 32'h9e37_79b1) ^ a;
        for (int a = 1024; a < 1024 + NUM_REQ*64; a++) mem[a] = rand_stim() % 16;
        for (int a = 2048; a < 2048 + 32*12; a++) begin
            case ((a - 2048) % 12)
                0, 1, 2:          mem[a] = small_fixed(20);     // about +-8.0
                3:                mem[a] = 32'h0001_0000;       // w = 1.0
                8, 9, 10, 11:     mem[a] = rand_stim() ^ (rand_stim() << 8);
                default:          ;
            endcase
        end
        // degenerate triangles: repeated vertex indices
        mem[1024 + 2*64 + 0] = 32'd4;
        mem[1024 + 2*64 + 1] = 32'd4;
        mem[1024 + 2*64 + 2] = 32'd4;
        mem[1024 + 3*64 + 3] = 32'd7;
        mem[1024 + 3*64 + 5] = 32'd7;

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int s = 0; s < NUM_REQ; s++) run_request(s);
        repeat (4) @(posedge clk);

        $display("tests %0d of %0d, errors %0d", tests, NUM_REQ, errors);
        if (errors == 0 && tests == NUM_REQ) begin
            $display("No errors");
        end else begin
            if (tests != NUM_REQ) $display("Not every request completed");
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* triangle_assembly.f */
+incdir+rtl
rtl/tri_asm_pkg.sv
rtl/vertex_fetch.sv
rtl/world_transform.sv
rtl/backface_issue.sv
rtl/triangle_assembly.sv
verification/triangle_checker.sv
verification/tb_triangle_assembly.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_triangle_assembly
FILELIST   ?= triangle_assembly.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= No errors
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
